// File: logic/crossy_core.sv
// top level of the game core wiring scheduler, lanes, resolver and state stage
`timescale 1ns/1ps

module crossy_core #(
    parameter int MOVE_DIV = 10_000_000,
    parameter int LANE_DIV = 3_000_000
) (
    input  logic                  CLOCK_50,
    input  logic                  rst,
    input  crossy_pkg::move_req_t move_p1,
    input  crossy_pkg::move_req_t move_p2,
    input  logic                  select_p1,
    input  logic                  select_p2,
    input  logic                  start_play,
    output crossy_pkg::cell_t     pos_p1,
    output crossy_pkg::cell_t     pos_p2,
    output crossy_pkg::heart_t    hearts_p1,
    output crossy_pkg::heart_t    hearts_p2,
    output logic                  alive_p1,
    output logic                  alive_p2,
    output logic                  start_screen,
    output logic                  end_screen
);
    import crossy_pkg::*;

    logic      step;
    move_req_t held_p1;
    move_req_t held_p2;
    game_st_t  state;
    coord_t    heads_a [2];
    coord_t    heads_b [3];
    coord_t    heads_c [2];
    coord_t    heads_d [2];

    step_if steps ();

    // ----------------------------------------
    // stage 1 and 2, timing and traffic
    // ----------------------------------------
    step_scheduler #(.MOVE_DIV(MOVE_DIV)) i_step_scheduler (
        .CLOCK_50 (CLOCK_50),
        .rst      (rst),
        .move_p1  (move_p1),
        .move_p2  (move_p2),
        .step     (step),
        .held_p1  (held_p1),
        .held_p2  (held_p2)
    );

    traffic_lanes #(.LANE_DIV(LANE_DIV)) i_traffic_lanes (
        .CLOCK_50 (CLOCK_50),
        .rst      (rst),
        .state    (state),
        .heads_a  (heads_a),
        .heads_b  (heads_b),
        .heads_c  (heads_c),
        .heads_d  (heads_d)
    );

    // ----------------------------------------
    // stage 3 and 4, decide then apply
    // ----------------------------------------
    move_resolver i_move_resolver (
        .held_p1   (held_p1),
        .held_p2   (held_p2),
        .select_p1 (select_p1),
        .select_p2 (select_p2),
        .pos_p1    (pos_p1),
        .pos_p2    (pos_p2),
        .alive_p1  (alive_p1),
        .alive_p2  (alive_p2),
        .heads_a   (heads_a),
        .heads_b   (heads_b),
        .heads_c   (heads_c),
        .heads_d   (heads_d),
        .steps     (steps.resolver)
    );

    game_state i_game_state (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .step       (step),
        .start_play (start_play),
        .steps      (steps.state),
        .state      (state),
        .pos_p1     (pos_p1),
        .pos_p2     (pos_p2),
        .hearts_p1  (hearts_p1),
        .hearts_p2  (hearts_p2),
        .alive_p1   (alive_p1),
        .alive_p2   (alive_p2)
    );

    // screen flags for the display side
    assign start_screen = (state == ST_START);
    assign end_screen   = (state == ST_END);

endmodule

// File: logic/crossy_pkg.sv
// grid sizes, cell and move types, start cells, tree table, car layout and game states
package crossy_pkg;

    // ----------------------------------------
    // grid and basic types
    // ----------------------------------------
    localparam int GRID_W = 16;
    localparam int GRID_H = 12;

    typedef logic [3:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_t;

    // one bit per direction, several can be held at once
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } move_req_t;

    typedef enum logic [1:0] {
        STAY   = 2'd0,
        MOVE   = 2'd1,
        STRUCK = 2'd2
    } step_act_t;

    typedef enum logic [1:0] {
        ST_START = 2'd0,
        ST_PLAY  = 2'd1,
        ST_END   = 2'd2
    } game_st_t;

    typedef logic [2:0] heart_t;
    localparam heart_t HEARTS_INIT = 3'd2;

    // both players spawn on the bottom row, side by side
    localparam cell_t P1_START = '{x: 4'd7, y: 4'd11};
    localparam cell_t P2_START = '{x: 4'd8, y: 4'd11};

    // ----------------------------------------
    // fixed obstacles
    // ----------------------------------------
    localparam int N_TREES = 5;
    localparam cell_t TREE_CELLS [N_TREES] = '{
        '{x: 4'd3,  y: 4'd7},
        '{x: 4'd12, y: 4'd7},
        '{x: 4'd5,  y: 4'd5},
        '{x: 4'd10, y: 4'd4},
        '{x: 4'd7,  y: 4'd1}
    };

    // ----------------------------------------
    // car lanes
    // ----------------------------------------
    localparam int CAR_LEN = 2;

    localparam coord_t ROW_A = 4'd10;
    localparam coord_t ROW_B = 4'd9;
    localparam coord_t ROW_C = 4'd3;
    localparam coord_t ROW_D = 4'd2;

    localparam int N_LANES = 4;
    localparam coord_t LANE_ROW   [N_LANES] = '{ROW_A, ROW_B, ROW_C, ROW_D};
    localparam bit     LANE_RIGHT [N_LANES] = '{1'b1, 1'b0, 1'b1, 1'b0};
    // lane period is LANE_DIV times this, lane A is the slowest
    localparam int     LANE_MULT  [N_LANES] = '{4, 3, 2, 1};
    localparam int     LANE_MULT_MAX = 4;

    // flat car table in lane order: A A B B B C C D D
    localparam int N_CARS = 9;
    localparam int     CAR_LANE  [N_CARS] = '{0, 0, 1, 1, 1, 2, 2, 3, 3};
    localparam coord_t CAR_START [N_CARS] = '{
        4'd0, 4'd8, 4'd1, 4'd6, 4'd11, 4'd2, 4'd10, 4'd2, 4'd10
    };

endpackage

// File: logic/game_state.sv
// game flow FSM with player cells, hearts and alive flags
`timescale 1ns/1ps

module game_state (
    input  logic                 CLOCK_50,
    input  logic                 rst,
    input  logic                 step,
    input  logic                 start_play,
    step_if.state                steps,
    output crossy_pkg::game_st_t state,
    output crossy_pkg::cell_t    pos_p1,
    output crossy_pkg::cell_t    pos_p2,
    output crossy_pkg::heart_t   hearts_p1,
    output crossy_pkg::heart_t   hearts_p2,
    output logic                 alive_p1,
    output logic                 alive_p2
);
    import crossy_pkg::*;

    typedef struct packed {
        cell_t  pos;
        heart_t hearts;
        logic   alive;
    } player_t;

    localparam player_t P1_INIT = '{pos: P1_START, hearts: HEARTS_INIT, alive: 1'b1};
    localparam player_t P2_INIT = '{pos: P2_START, hearts: HEARTS_INIT, alive: 1'b1};

    game_st_t state_q;
    game_st_t state_d;
    player_t  p1_q;
    player_t  p2_q;

    // dead players keep their last cell and count
    function automatic player_t apply(player_t p, step_act_t act, cell_t nxt,
                                      cell_t start);
        player_t r;
        r = p;
        if (p.alive) begin
            case (act)
                MOVE: begin
                    r.pos = nxt;
                end
                STRUCK: begin
                    if (p.hearts != 3'd0) begin
                        r.hearts = p.hearts - 3'd1;
                        // last heart gone
                        r.alive = (p.hearts != 3'd1);
                    end
                    r.pos = start;
                end
                default: begin
                    r = p;
                end
            endcase
        end
        return r;
    endfunction

    // ----------------------------------------
    // game flow
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_START: if (start_play) state_d = ST_PLAY;
            // both players across the road
            ST_PLAY:  if (p1_q.pos.y == 4'd0 && p2_q.pos.y == 4'd0) state_d = ST_END;
            ST_END:   if (!start_play) state_d = ST_START;
            default:  state_d = ST_START;
        endcase
    end

    // ----------------------------------------
    // player registers
    // ----------------------------------------
    always_ff @(posedge CLOCK_50 or negedge rst) begin
        if (!rst) begin
            state_q <= ST_START;
            p1_q    <= P1_INIT;
            p2_q    <= P2_INIT;
        end else begin
            state_q <= state_d;
            if (state_q == ST_START) begin
                p1_q <= P1_INIT;
                p2_q <= P2_INIT;
            end else if (state_q == ST_PLAY && step) begin
                p1_q <= apply(p1_q, steps.act_p1, steps.next_p1, P1_START);
                p2_q <= apply(p2_q, steps.act_p2, steps.next_p2, P2_START);
            end
        end
    end

    assign state     = state_q;
    assign pos_p1    = p1_q.pos;
    assign pos_p2    = p2_q.pos;
    assign hearts_p1 = p1_q.hearts;
    assign hearts_p2 = p2_q.hearts;
    assign alive_p1  = p1_q.alive;
    assign alive_p2  = p2_q.alive;

    // only a new game refills hearts
    a_hearts_no_gain : assert property (@(posedge CLOCK_50) disable iff (!rst)
        (state_q != ST_START) |=>
            (hearts_p1 <= $past(hearts_p1)) && (hearts_p2 <= $past(hearts_p2)))
        else $error("hearts increased outside START");

endmodule

// File: logic/move_resolver.sv
// next cells, tree and player blocking, car hits and the per-player step decision
`timescale 1ns/1ps

module move_resolver (
    input  crossy_pkg::move_req_t held_p1,
    input  crossy_pkg::move_req_t held_p2,
    input  logic                  select_p1,
    input  logic                  select_p2,
    input  crossy_pkg::cell_t     pos_p1,
    input  crossy_pkg::cell_t     pos_p2,
    input  logic                  alive_p1,
    input  logic                  alive_p2,
    input  crossy_pkg::coord_t    heads_a [2],
    input  crossy_pkg::coord_t    heads_b [3],
    input  crossy_pkg::coord_t    heads_c [2],
    input  crossy_pkg::coord_t    heads_d [2],
    step_if.resolver              steps
);
    import crossy_pkg::*;

    coord_t    all_heads [N_CARS];
    cell_t     nxt_p1;
    cell_t     nxt_p2;
    step_act_t act_p1;
    step_act_t act_p2;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    // priority up, down, left, right, stopped by the grid edge
    function automatic cell_t next_cell(cell_t pos, move_req_t mv);
        cell_t nc;
        nc = pos;
        if (mv.up && pos.y > 4'd0) begin
            nc.y = pos.y - 4'd1;
        end else if (mv.down && pos.y < 4'(GRID_H - 1)) begin
            nc.y = pos.y + 4'd1;
        end else if (mv.left && pos.x > 4'd0) begin
            nc.x = pos.x - 4'd1;
        end else if (mv.right && pos.x < 4'(GRID_W - 1)) begin
            nc.x = pos.x + 4'd1;
        end
        return nc;
    endfunction

    function automatic logic is_tree(cell_t c);
        logic found;
        found = 1'b0;
        for (int t = 0; t < N_TREES; t++) begin
            found = found | (c == TREE_CELLS[t]);
        end
        return found;
    endfunction

    // a car covers head to head+CAR_LEN-1 with no wrap of the body
    function automatic logic car_hit(cell_t pos, coord_t heads [N_CARS]);
        logic       hit;
        logic [4:0] hx;
        hit = 1'b0;
        for (int i = 0; i < N_CARS; i++) begin
            hx = {1'b0, heads[i]};
            if (pos.y == LANE_ROW[CAR_LANE[i]] && {1'b0, pos.x} >= hx &&
                {1'b0, pos.x} < hx + 5'(CAR_LEN)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // neighbours differ by one in exactly one coordinate, no wrap at the edge
    function automatic logic one_step(cell_t a, cell_t b);
        logic dx;
        logic dy;
        dx = ({1'b0, a.x} == {1'b0, b.x} + 5'd1) || ({1'b0, b.x} == {1'b0, a.x} + 5'd1);
        dy = ({1'b0, a.y} == {1'b0, b.y} + 5'd1) || ({1'b0, b.y} == {1'b0, a.y} + 5'd1);
        return (dx && a.y == b.y) || (dy && a.x == b.x);
    endfunction

    function automatic step_act_t decide(logic sel, cell_t pos, cell_t nxt,
                                         cell_t other, logic other_alive,
                                         coord_t heads [N_CARS]);
        if (!sel) begin
            return STAY;
        end else if (car_hit(pos, heads)) begin
            return STRUCK;
        end else if (nxt != pos && !is_tree(nxt) && !(other_alive && nxt == other)) begin
            return MOVE;
        end
        return STAY;
    endfunction

    // ----------------------------------------
    // decisions
    // ----------------------------------------
    always_comb begin
        all_heads = '{heads_a[0], heads_a[1], heads_b[0], heads_b[1], heads_b[2],
                      heads_c[0], heads_c[1], heads_d[0], heads_d[1]};
        nxt_p1 = next_cell(pos_p1, held_p1);
        nxt_p2 = next_cell(pos_p2, held_p2);
        // blocking looks at where the other player stands now
        act_p1 = decide(select_p1, pos_p1, nxt_p1, pos_p2, alive_p2, all_heads);
        act_p2 = decide(select_p2, pos_p2, nxt_p2, pos_p1, alive_p1, all_heads);

        // a MOVE always lands on a neighbouring cell
        if (act_p1 == MOVE) begin
            a_move_p1 : assert (one_step(pos_p1, nxt_p1))
                else $error("player 1 MOVE to a cell that is not a neighbour");
        end
        if (act_p2 == MOVE) begin
            a_move_p2 : assert (one_step(pos_p2, nxt_p2))
                else $error("player 2 MOVE to a cell that is not a neighbour");
        end
    end

    assign steps.act_p1  = act_p1;
    assign steps.act_p2  = act_p2;
    assign steps.next_p1 = nxt_p1;
    assign steps.next_p2 = nxt_p2;

endmodule

// File: logic/step_if.sv
// per-player step decisions passed from the move resolver to the state stage
`timescale 1ns/1ps

interface step_if;
    import crossy_pkg::*;

    // decision per player, valid in any cycle, used only when step is high
    step_act_t act_p1;
    step_act_t act_p2;

    // candidate cell for a MOVE
    cell_t next_p1;
    cell_t next_p2;

    modport resolver (
        output act_p1,
        output act_p2,
        output next_p1,
        output next_p2
    );

    modport state (
        input act_p1,
        input act_p2,
        input next_p1,
        input next_p2
    );

endinterface

// File: logic/step_scheduler.sv
// movement divider producing the step strobe and the move pulse latches
`timescale 1ns/1ps

module step_scheduler #(
    parameter int MOVE_DIV = 10_000_000
) (
    input  logic                  CLOCK_50,
    input  logic                  rst,
    input  crossy_pkg::move_req_t move_p1,
    input  crossy_pkg::move_req_t move_p2,
    output logic                  step,
    output crossy_pkg::move_req_t held_p1,
    output crossy_pkg::move_req_t held_p2
);
    import crossy_pkg::*;

    localparam int CNT_W = (MOVE_DIV > 1) ? $clog2(MOVE_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;

    // ----------------------------------------
    // step divider
    // ----------------------------------------
    // free running in every game state, step follows the terminal count
    always_ff @(posedge CLOCK_50 or negedge rst) begin
        if (!rst) begin
            div_cnt <= '0;
            step    <= 1'b0;
        end else if (div_cnt == CNT_W'(MOVE_DIV - 1)) begin
            div_cnt <= '0;
            step    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            step    <= 1'b0;
        end
    end

    // ----------------------------------------
    // move latches
    // ----------------------------------------
    // pulses accumulate until the step has used them
    // a pulse landing in the step cycle itself is dropped
    always_ff @(posedge CLOCK_50 or negedge rst) begin
        if (!rst) begin
            held_p1 <= '0;
            held_p2 <= '0;
        end else if (step) begin
            held_p1 <= '0;
            held_p2 <= '0;
        end else begin
            held_p1 <= held_p1 | move_p1;
            held_p2 <= held_p2 | move_p2;
        end
    end

    // the state stage relies on one update per step
    a_step_single : assert property (@(posedge CLOCK_50) disable iff (!rst)
        step |=> !step)
        else $error("step strobe high on two cycles in a row");

endmodule

// File: logic/traffic_lanes.sv
// car head counters for the four car rows
`timescale 1ns/1ps

module traffic_lanes #(
    parameter int LANE_DIV = 3_000_000
) (
    input  logic                 CLOCK_50,
    input  logic                 rst,
    input  crossy_pkg::game_st_t state,
    output crossy_pkg::coord_t   heads_a [2],
    output crossy_pkg::coord_t   heads_b [3],
    output crossy_pkg::coord_t   heads_c [2],
    output crossy_pkg::coord_t   heads_d [2]
);
    import crossy_pkg::*;

    localparam int PER_W = $clog2(LANE_DIV * LANE_MULT_MAX + 1);

    logic [PER_W-1:0] per_cnt   [N_LANES];
    logic             lane_tick [N_LANES];
    coord_t           heads_q   [N_CARS];

    // ----------------------------------------
    // lane period counters
    // ----------------------------------------
    // terminal count marks the shift cycle of each lane
    always_comb begin
        for (int l = 0; l < N_LANES; l++) begin
            lane_tick[l] = (state == ST_PLAY) &&
                           (per_cnt[l] == PER_W'(LANE_DIV * LANE_MULT[l] - 1));
        end
    end

    // counters sit at zero until play starts
    always_ff @(posedge CLOCK_50 or negedge rst) begin
        if (!rst) begin
            for (int l = 0; l < N_LANES; l++) begin
                per_cnt[l] <= '0;
            end
        end else begin
            for (int l = 0; l < N_LANES; l++) begin
                if (state != ST_PLAY || lane_tick[l]) begin
                    per_cnt[l] <= '0;
                end else begin
                    per_cnt[l] <= per_cnt[l] + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // car heads
    // ----------------------------------------
    // 4-bit heads wrap modulo 16 on their own
    always_ff @(posedge CLOCK_50 or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < N_CARS; i++) begin
                heads_q[i] <= CAR_START[i];
            end
        end else begin
            for (int i = 0; i < N_CARS; i++) begin
                if (state != ST_PLAY) begin
                    heads_q[i] <= CAR_START[i];
                end else if (lane_tick[CAR_LANE[i]]) begin
                    heads_q[i] <= LANE_RIGHT[CAR_LANE[i]] ? heads_q[i] + 4'd1
                                                          : heads_q[i] - 4'd1;
                end
            end
        end
    end

    // split the flat table back into rows
    assign heads_a[0] = heads_q[0];
    assign heads_a[1] = heads_q[1];
    assign heads_b[0] = heads_q[2];
    assign heads_b[1] = heads_q[3];
    assign heads_b[2] = heads_q[4];
    assign heads_c[0] = heads_q[5];
    assign heads_c[1] = heads_q[6];
    assign heads_d[0] = heads_q[7];
    assign heads_d[1] = heads_q[8];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the game core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module crossy_tb -o crossy_sim
./obj_dir/crossy_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: verification/crossy_tb_table.svh
// stimulus table of game rows with expected cells, hearts, alive and screen flags
`ifndef CROSSY_TB_TABLE_SVH
`define CROSSY_TB_TABLE_SVH

// columns: sel1 sel2 start steps | mv1 mv2 (one nibble per step, step 0 lowest)
//          | pos_p1 pos_p2 (x,y hex) hearts_p1 hearts_p2 alive_p1 alive_p2 start end
// move nibble: 8 up, 4 down, 2 left, 1 right
localparam int N_ROWS = 11;
localparam row_t ROWS [N_ROWS] = '{
    // idle in START, the up pulse is ignored
    '{1'b1, 1'b1, 1'b0, 4'd1, 32'h0000_0008, 32'h0000_0000,
      8'h7B, 8'h8B, 3'd2, 3'd2, 1'b1, 1'b1, 1'b1, 1'b0},
    // enter PLAY
    '{1'b1, 1'b1, 1'b1, 4'd1, 32'h0000_0000, 32'h0000_0000,
      8'h7B, 8'h8B, 3'd2, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0},
    // down at the bottom edge, then left, p2 not selected
    '{1'b1, 1'b0, 1'b1, 4'd2, 32'h0000_0024, 32'h0000_0088,
      8'h6B, 8'h8B, 3'd2, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0},
    // p2 steps left, p1 then blocked by p2
    '{1'b1, 1'b1, 1'b1, 4'd2, 32'h0000_0010, 32'h0000_0002,
      8'h6B, 8'h7B, 3'd2, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0},
    // cross rows 10 and 9, p1 stopped by the tree at (3,7)
    '{1'b1, 1'b1, 1'b1, 4'd7, 32'h0888_8222, 32'h0888_8801,
      8'h38, 8'h86, 3'd2, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0},
    // cross rows 3 and 2, p2 reaches the top and pushes the edge
    '{1'b1, 1'b1, 1'b1, 4'd8, 32'h8888_8881, 32'h0888_8888,
      8'h41, 8'h80, 3'd2, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0},
    // p1 reaches the top, game over screen
    '{1'b1, 1'b1, 1'b1, 4'd1, 32'h0000_0008, 32'h0000_0000,
      8'h40, 8'h80, 3'd2, 3'd2, 1'b1, 1'b1, 1'b0, 1'b1},
    // back to START restores everything
    '{1'b1, 1'b1, 1'b0, 4'd1, 32'h0000_0000, 32'h0000_0000,
      8'h7B, 8'h8B, 3'd2, 3'd2, 1'b1, 1'b1, 1'b1, 1'b0},
    // second game
    '{1'b1, 1'b1, 1'b1, 4'd1, 32'h0000_0000, 32'h0000_0000,
      8'h7B, 8'h8B, 3'd2, 3'd2, 1'b1, 1'b1, 1'b0, 1'b0},
    // p2 walks into the row A car
    '{1'b1, 1'b1, 1'b1, 4'd2, 32'h0000_0000, 32'h0000_0008,
      8'h7B, 8'h8B, 3'd2, 3'd1, 1'b1, 1'b1, 1'b0, 1'b0},
    // second hit kills p2, p1 may then take its cell
    '{1'b1, 1'b1, 1'b1, 4'd4, 32'h0000_1000, 32'h0000_0808,
      8'h8B, 8'h8B, 3'd2, 3'd0, 1'b1, 1'b0, 1'b0, 1'b0}
};

`endif

// File: verification/crossy_tb.sv
// testbench for the game core with table rows, step reference model, checks and timeout
`timescale 1ns/1ps

module crossy_tb;
    import crossy_pkg::*;

    localparam int MOVE_DIV = 8;
    localparam int LANE_DIV = 16;

    typedef struct packed {
        logic        sel1;
        logic        sel2;
        logic        start;
        logic [3:0]  steps;
        logic [31:0] mv1;
        logic [31:0] mv2;
        cell_t       exp1;
        cell_t       exp2;
        heart_t      h1;
        heart_t      h2;
        logic        a1;
        logic        a2;
        logic        ss;
        logic        es;
    } row_t;

    `include "crossy_tb_table.svh"

    logic      CLOCK_50;
    logic      rst;
    move_req_t move_p1;
    move_req_t move_p2;
    logic      select_p1;
    logic      select_p2;
    logic      start_play;
    cell_t     pos_p1;
    cell_t     pos_p2;
    heart_t    hearts_p1;
    heart_t    hearts_p2;
    logic      alive_p1;
    logic      alive_p2;
    logic      start_screen;
    logic      end_screen;

    int cyc;
    int limit;
    int errors;

    // model state
    game_st_t m_st;
    cell_t    m_pos [2];
    heart_t   m_hearts [2];
    logic     m_alive [2];
    int       play0;

    crossy_core #(.MOVE_DIV(MOVE_DIV), .LANE_DIV(LANE_DIV)) i_crossy_core (
        .CLOCK_50 (CLOCK_50), .rst (rst),
        .move_p1 (move_p1), .move_p2 (move_p2),
        .select_p1 (select_p1), .select_p2 (select_p2), .start_play (start_play),
        .pos_p1 (pos_p1), .pos_p2 (pos_p2),
        .hearts_p1 (hearts_p1), .hearts_p2 (hearts_p2),
        .alive_p1 (alive_p1), .alive_p2 (alive_p2),
        .start_screen (start_screen), .end_screen (end_screen)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    // cycles since reset release
    // steps fall on multiples of MOVE_DIV
    always @(posedge CLOCK_50 or negedge rst) begin
        if (!rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(posedge CLOCK_50) begin
        if (limit > 0 && cyc > limit) begin
            $display("timeout: the rows did not finish within %0d cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // head column after play_cyc cycles of PLAY
    function automatic int car_col(int i, int play_cyc);
        int k;
        int c;
        k = play_cyc / (LANE_DIV * LANE_MULT[CAR_LANE[i]]);
        c = int'(CAR_START[i]);
        if (LANE_RIGHT[CAR_LANE[i]]) begin
            return (c + k) % GRID_W;
        end
        return ((c - k) % GRID_W + GRID_W) % GRID_W;
    endfunction

    function automatic logic under_car(cell_t c, int play_cyc);
        int   h;
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < N_CARS; i++) begin
            h = car_col(i, play_cyc);
            if (c.y == LANE_ROW[CAR_LANE[i]] && int'(c.x) >= h && int'(c.x) < h + CAR_LEN) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic cell_t target(cell_t c, move_req_t m);
        cell_t t;
        t = c;
        if (m.up && c.y != 4'd0) t.y = c.y - 4'd1;
        else if (m.down && c.y != 4'd11) t.y = c.y + 4'd1;
        else if (m.left && c.x != 4'd0) t.x = c.x - 4'd1;
        else if (m.right && c.x != 4'd15) t.x = c.x + 4'd1;
        return t;
    endfunction

    function automatic logic on_tree(cell_t c);
        logic f;
        f = 1'b0;
        for (int t = 0; t < N_TREES; t++) begin
            if (c == TREE_CELLS[t]) f = 1'b1;
        end
        return f;
    endfunction

    task automatic init_players();
        m_pos[0] = P1_START;
        m_pos[1] = P2_START;
        for (int i = 0; i < 2; i++) begin
            m_hearts[i] = HEARTS_INIT;
            m_alive[i]  = 1'b1;
        end
    endtask

    // both decisions from the state before the step, then apply
    task automatic predict_step(move_req_t m1, move_req_t m2, logic s1, logic s2, int pc);
        cell_t     nxt [2];
        step_act_t act [2];
        logic      sel [2];
        sel[0] = s1;
        sel[1] = s2;
        nxt[0] = target(m_pos[0], m1);
        nxt[1] = target(m_pos[1], m2);
        for (int i = 0; i < 2; i++) begin
            act[i] = STAY;
            if (sel[i] && under_car(m_pos[i], pc)) act[i] = STRUCK;
            else if (sel[i] && nxt[i] != m_pos[i] && !on_tree(nxt[i]) &&
                     !(m_alive[1-i] && nxt[i] == m_pos[1-i])) act[i] = MOVE;
        end
        for (int i = 0; i < 2; i++) begin
            if (m_alive[i] && act[i] == MOVE) m_pos[i] = nxt[i];
            if (m_alive[i] && act[i] == STRUCK) begin
                if (m_hearts[i] != 3'd0) m_hearts[i] = m_hearts[i] - 3'd1;
                if (m_hearts[i] == 3'd0) m_alive[i] = 1'b0;
                m_pos[i] = (i == 0) ? P1_START : P2_START;
            end
        end
        if (m_pos[0].y == 4'd0 && m_pos[1].y == 4'd0) m_st = ST_END;
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic check_val(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_row(row_t r);
        check_val("pos_p1", pos_p1, r.exp1);
        check_val("pos_p2", pos_p2, r.exp2);
        check_val("hearts_p1", 8'(hearts_p1), 8'(r.h1));
        check_val("hearts_p2", 8'(hearts_p2), 8'(r.h2));
        check_val("alive_p1", 8'(alive_p1), 8'(r.a1));
        check_val("alive_p2", 8'(alive_p2), 8'(r.a2));
        check_val("start_screen", 8'(start_screen), 8'(r.ss));
        check_val("end_screen", 8'(end_screen), 8'(r.es));
        // model against the table rows
        check_val("model pos_p1", m_pos[0], r.exp1);
        check_val("model pos_p2", m_pos[1], r.exp2);
        check_val("model hearts_p1", 8'(m_hearts[0]), 8'(r.h1));
        check_val("model hearts_p2", 8'(m_hearts[1]), 8'(r.h2));
        check_val("model alive_p1", 8'(m_alive[0]), 8'(r.a1));
        check_val("model alive_p2", 8'(m_alive[1]), 8'(r.a2));
        check_val("model end_screen", 8'(m_st == ST_END), 8'(r.es));
    endtask

    // next falling edge at the given cycle phase
    task automatic wait_phase(int ph);
        do @(negedge CLOCK_50); while (cyc % MOVE_DIV != ph);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int          pick;
        int          err0;
        int          passed;
        int          failed;
        row_t        r;
        move_req_t   m1;
        move_req_t   m2;
        void'($urandom(67444));
        limit = 0;
        errors = 0;
        passed = 0;
        failed = 0;
        rst = 1'b0;
        move_p1 = '0;
        move_p2 = '0;
        select_p1 = 1'b0;
        select_p2 = 1'b0;
        start_play = 1'b0;
        m_st = ST_START;
        play0 = 0;
        init_players();
        for (int i = 0; i < N_ROWS; i++) limit += int'(ROWS[i].steps) * MOVE_DIV;
        limit += 200;
        repeat (3) @(negedge CLOCK_50);
        rst = 1'b1;
        wait_phase(2);
        for (int i = 0; i < N_ROWS; i++) begin
            r = ROWS[i];
            err0 = errors;
            select_p1 = r.sel1;
            select_p2 = r.sel2;
            start_play = r.start;
            // FSM change takes effect on the next rising edge
            if (m_st == ST_START && r.start) begin
                m_st = ST_PLAY;
                play0 = cyc + 1;
            end else if (m_st == ST_END && !r.start) begin
                m_st = ST_START;
            end
            if (m_st == ST_START) init_players();
            for (int s = 0; s < int'(r.steps); s++) begin
                m1 = r.mv1[4*s +: 4];
                m2 = r.mv2[4*s +: 4];
                wait_phase(3);
                move_p1 = m1;
                move_p2 = m2;
                @(negedge CLOCK_50);
                move_p1 = '0;
                move_p2 = '0;
                // repeat one pulse inside the same interval
                wait_phase(5);
                pick = int'($urandom % 2);
                if (pick == 0) move_p1 = m1;
                else move_p2 = m2;
                @(negedge CLOCK_50);
                move_p1 = '0;
                move_p2 = '0;
                wait_phase(1);
                if (m_st == ST_PLAY) predict_step(m1, m2, r.sel1, r.sel2, cyc - 1 - play0);
            end
            wait_phase(2);
            compare_row(r);
            if (errors == err0) begin
                passed++;
                $display("row %0d done, ok", i);
            end else begin
                failed++;
                $display("row %0d done, %0d mismatches", i, errors - err0);
            end
        end
        $display("rows passed %0d, rows failed %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
logic/crossy_pkg.sv
logic/step_if.sv
logic/step_scheduler.sv
logic/traffic_lanes.sv
logic/move_resolver.sv
logic/game_state.sv
logic/crossy_core.sv
verification/crossy_tb.sv
